/* hdl/aluPkg.sv */
`default_nettype none

package aluPkg;

	// ----------------------------
	// Datapath sizes
	// ----------------------------
	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regIdxWidth = 4;

	// Instruction queue
	localparam int fifoDepth = 4;
	localparam int fifoPtrWidth = $clog2(fifoDepth);
	localparam int countWidth = $clog2(fifoDepth + 1);

	// AXI4-Lite bus
	localparam int busWidth = 32;
	localparam int addrWidth = 32;

	localparam logic [addrWidth-1:0] instrAddr = 32'h0000_0000;
	localparam logic [addrWidth-1:0] regBase = 32'h0000_0000;
	localparam logic [addrWidth-1:0] flagAddr = 32'h0000_0040;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// ----------------------------
	// Opcodes and flags
	// ----------------------------
	typedef enum logic [4:0] {
		opAdd = 5'd0,
		opSub = 5'd1,
		opCmp = 5'd2,
		opAnd = 5'd3,
		opOr = 5'd4,
		opXor = 5'd5,
		opNot = 5'd6,
		opLsh = 5'd7,
		opRsh = 5'd8,
		opArsh = 5'd9,
		opMov = 5'd10
	} aluOp;

	// Bit positions inside the flag register
	localparam int flagC = 0;
	localparam int flagL = 1;
	localparam int flagF = 2;
	localparam int flagZ = 3;
	localparam int flagN = 4;

	typedef logic [4:0] aluFlags;

	// Instruction word as written by the host
	typedef struct packed {
		logic [7:0] imm8;
		logic [5:0] spareHi;
		logic signedImm;
		logic useImm;
		logic [3:0] src;
		logic [3:0] dest;
		logic [2:0] spareLo;
		logic [4:0] opcode;
	} instrWord;

	// Decoded instruction whose operand holds the source index when useImm is clear
	typedef struct packed {
		aluOp op;
		logic [regIdxWidth-1:0] dest;
		logic useImm;
		logic [dataWidth-1:0] operand;
	} execInstr;

endpackage

`default_nettype wire

/* hdl/aluCore.sv */
`default_nettype none

module aluCore import aluPkg::*; (
	input aluOp op,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input aluFlags flagsIn,
	output logic [dataWidth-1:0] result,
	output aluFlags flagsOut,
	output logic writesReg
);

	logic [dataWidth-1:0] addB;
	logic carryIn;
	logic [dataWidth:0] sum;
	logic overflow;
	logic ltUnsigned;
	logic ltSigned;
	logic equal;

	// ----------------------------
	// Shared adder for ADD and SUB
	// ----------------------------

	// SUB is a + ~b + 1
	always_comb begin
		addB = b;
		carryIn = 1'b0;
		if (op == opSub) begin
			addB = ~b;
			carryIn = 1'b1;
		end
	end

	assign sum = {1'b0, a} + {1'b0, addB} + {{dataWidth{1'b0}}, carryIn};

	// Operands of one sign giving a result of the other sign
	assign overflow = (a[dataWidth-1] == addB[dataWidth-1]) &&
		(sum[dataWidth-1] != a[dataWidth-1]);

	// Comparisons are always of the destination against the original b
	assign ltUnsigned = a < b;
	assign ltSigned = $signed(a) < $signed(b);
	assign equal = a == b;

	// ----------------------------
	// Result and flag select
	// ----------------------------
	always_comb begin
		result = b;
		flagsOut = flagsIn;
		writesReg = 1'b1;

		case (op)
			opAdd, opSub: begin
				result = sum[dataWidth-1:0];
				flagsOut[flagC] = sum[dataWidth];
				flagsOut[flagL] = ltUnsigned;
				flagsOut[flagF] = overflow;
				flagsOut[flagZ] = equal;
				flagsOut[flagN] = ltSigned;
			end
			opCmp: begin
				// Compare only so C and F keep their old value
				result = a;
				writesReg = 1'b0;
				flagsOut[flagL] = ltUnsigned;
				flagsOut[flagZ] = equal;
				flagsOut[flagN] = ltSigned;
			end
			opAnd: begin
				result = a & b;
			end
			opOr: begin
				result = a | b;
			end
			opXor: begin
				result = a ^ b;
			end
			opNot: begin
				result = ~b;
			end
			opLsh: begin
				result = b << 1;
			end
			opRsh: begin
				result = b >> 1;
			end
			opArsh: begin
				result = $unsigned($signed(b) >>> 1);
			end
			opMov: begin
				result = b;
			end
			default: begin
				// Never queued by the bus port
				result = a;
				writesReg = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/instrFifo.sv */
`default_nettype none

module instrFifo import aluPkg::*; #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rstN,
	input logic push,
	input payloadT pushData,
	output logic popValid,
	output payloadT popData,
	input logic pop,
	output logic [countWidth-1:0] count
);

	payloadT mem [fifoDepth];
	logic [fifoPtrWidth-1:0] wrPtr;
	logic [fifoPtrWidth-1:0] rdPtr;
	logic doPop;

	assign popValid = count != '0;
	assign popData = mem[rdPtr];
	assign doPop = pop && popValid;

	// Storage written on every push
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= pushData;
		end
	end

	// ----------------------------
	// Pointers and occupancy
	// ----------------------------
	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == fifoPtrWidth'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == fifoPtrWidth'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({push, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/executeUnit.sv */
`default_nettype none

module executeUnit import aluPkg::*; (
	input logic clk,
	input logic rstN,
	input logic popValid,
	input execInstr popData,
	output logic pop,
	output logic busy,
	input logic [regIdxWidth-1:0] rdIdx,
	output logic [dataWidth-1:0] rdData,
	output aluFlags flags
);

	logic [dataWidth-1:0] regFile [regCount];
	aluFlags flagReg;
	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] result;
	aluFlags flagsNext;
	logic writesReg;
	logic [regIdxWidth-1:0] srcIdx;

	// ----------------------------
	// Operand fetch
	// ----------------------------
	assign srcIdx = popData.operand[regIdxWidth-1:0];
	assign operandA = regFile[popData.dest];
	assign operandB = popData.useImm ? popData.operand : regFile[srcIdx];

	aluCore i_aluCore (
		.op(popData.op),
		.a(operandA),
		.b(operandB),
		.flagsIn(flagReg),
		.result(result),
		.flagsOut(flagsNext),
		.writesReg(writesReg)
	);

	// One instruction retires in every cycle the queue has one
	assign pop = popValid;
	assign busy = popValid;

	// ----------------------------
	// Register file and flags
	// ----------------------------
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regFile[i] <= '0;
			end
			flagReg <= '0;
		end else if (popValid) begin
			if (writesReg) begin
				regFile[popData.dest] <= result;
			end
			flagReg <= flagsNext;
		end
	end

	// Read port for the bus
	assign rdData = regFile[rdIdx];
	assign flags = flagReg;

endmodule

`default_nettype wire

/* hdl/aluBusPort.sv */
`default_nettype none

module aluBusPort import aluPkg::*; (
	input logic clk,
	input logic rstN,
	input logic awvalid,
	output logic awready,
	input logic [addrWidth-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [busWidth-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [addrWidth-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [busWidth-1:0] rdata,
	output logic [1:0] rresp,
	output logic push,
	output execInstr pushData,
	input logic [countWidth-1:0] fifoCount,
	input logic busy,
	output logic [regIdxWidth-1:0] rdIdx,
	input logic [dataWidth-1:0] rdData,
	input aluFlags flags
);

	instrWord word;
	logic [dataWidth-1:0] immExt;
	logic busUp;
	logic wrAccept;
	logic wrGood;
	logic rdAccept;
	logic [addrWidth-1:0] regOffset;
	logic regHit;
	logic flagHit;

	// Ready comes up one cycle after reset is released
	always_ff @(posedge clk) begin
		if (!rstN) begin
			busUp <= 1'b0;
		end else begin
			busUp <= 1'b1;
		end
	end

	// ----------------------------
	// Write channel and decode
	// ----------------------------
	assign word = instrWord'(wdata);

	// Sign or zero extension of the 8-bit immediate
	assign immExt = {{(dataWidth - 8){word.signedImm & word.imm8[7]}}, word.imm8};

	assign awready = busUp && !bvalid && (fifoCount != countWidth'(fifoDepth));
	assign wready = awready;
	assign wrAccept = awvalid && wvalid && awready;
	assign wrGood = (awaddr == instrAddr) && (word.opcode <= opMov);

	assign push = wrAccept && wrGood;

	always_comb begin
		pushData.op = aluOp'(word.opcode);
		pushData.dest = word.dest;
		pushData.useImm = word.useImm;
		pushData.operand = word.useImm ? immExt : dataWidth'(word.src);
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			bvalid <= 1'b0;
		end else if (wrAccept) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wrAccept) begin
			bresp <= wrGood ? respOkay : respSlvErr;
		end
	end

	// ----------------------------
	// Read channel
	// ----------------------------

	// Reads wait until the queue has drained
	assign arready = busUp && (fifoCount == '0) && !busy && !rvalid;
	assign rdAccept = arvalid && arready;

	assign regOffset = araddr - regBase;
	assign regHit = (regOffset < addrWidth'(4 * regCount)) && (regOffset[1:0] == 2'b00);
	assign flagHit = araddr == flagAddr;
	assign rdIdx = regOffset[regIdxWidth+1:2];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rvalid <= 1'b0;
		end else if (rdAccept) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rdAccept) begin
			rresp <= respOkay;
			if (regHit) begin
				rdata <= busWidth'(rdData);
			end else if (flagHit) begin
				rdata <= busWidth'(flags);
			end else begin
				rdata <= '0;
				rresp <= respSlvErr;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/aluTop.sv */
`default_nettype none

module aluTop import aluPkg::*; (
	input logic clk,
	input logic rstN,
	input logic awvalid,
	output logic awready,
	input logic [addrWidth-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [busWidth-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [addrWidth-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [busWidth-1:0] rdata,
	output logic [1:0] rresp
);

	logic push;
	execInstr pushData;
	logic popValid;
	execInstr popData;
	logic pop;
	logic [countWidth-1:0] fifoCount;
	logic busy;
	logic [regIdxWidth-1:0] rdIdx;
	logic [dataWidth-1:0] rdData;
	aluFlags flags;

	// ----------------------------
	// Bus port, queue, execute
	// ----------------------------
	aluBusPort i_aluBusPort (
		.clk(clk),
		.rstN(rstN),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.push(push),
		.pushData(pushData),
		.fifoCount(fifoCount),
		.busy(busy),
		.rdIdx(rdIdx),
		.rdData(rdData),
		.flags(flags)
	);

	instrFifo #(
		.payloadT(execInstr)
	) i_instrFifo (
		.clk(clk),
		.rstN(rstN),
		.push(push),
		.pushData(pushData),
		.popValid(popValid),
		.popData(popData),
		.pop(pop),
		.count(fifoCount)
	);

	executeUnit i_executeUnit (
		.clk(clk),
		.rstN(rstN),
		.popValid(popValid),
		.popData(popData),
		.pop(pop),
		.busy(busy),
		.rdIdx(rdIdx),
		.rdData(rdData),
		.flags(flags)
	);

endmodule

`default_nettype wire

/* tb/aluTop_assert.sv */
`default_nettype none

module aluAssert import aluPkg::*; (
	input logic clk,
	input logic rstN,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic push,
	input logic [countWidth-1:0] fifoCount,
	input logic arready,
	input logic busy
);

	timeunit 1ns;
	timeprecision 100ps;

	// Responses hold until the host takes them
	bvalidHeld: assert property (@(posedge clk) disable iff (!rstN)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	rvalidHeld: assert property (@(posedge clk) disable iff (!rstN)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// Queue overflow
	pushNotFull: assert property (@(posedge clk) disable iff (!rstN)
		push |-> fifoCount != countWidth'(fifoDepth))
		else $error("push into a full FIFO");

	// Reads wait for the execute unit to drain
	readIdle: assert property (@(posedge clk) disable iff (!rstN)
		busy |-> !arready)
		else $error("arready high while the execute unit is busy");

endmodule

bind aluTop aluAssert i_aluAssert (
	.clk(clk),
	.rstN(rstN),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready),
	.push(push),
	.fifoCount(fifoCount),
	.arready(arready),
	.busy(busy)
);

`default_nettype wire

/* tb/aluTb.sv */
`default_nettype none

module aluTb import aluPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeoutCycles = 1000;

	logic clk;
	logic rstN;
	logic awvalid;
	logic awready;
	logic [addrWidth-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [busWidth-1:0] wdata;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [addrWidth-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [busWidth-1:0] rdata;
	logic [1:0] rresp;

	// Reference model state
	logic [dataWidth-1:0] modelRegs [regCount];
	aluFlags modelFlags;

	// Expected responses in issue order
	logic [1:0] expBrespQ [$];
	logic [addrWidth-1:0] expAddrQ [$];
	logic [busWidth-1:0] expRdataQ [$];
	logic [1:0] expRrespQ [$];

	int errorCount = 0;
	int checkCount = 0;

	aluTop i_aluTop (
		.clk(clk),
		.rstN(rstN),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp)
	);

	always #4 clk = ~clk;

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic logic [dataWidth-1:0] immExtend(input logic [7:0] imm8, input logic sx);
		return sx ? {{8{imm8[7]}}, imm8} : {8'h00, imm8};
	endfunction

	function automatic logic [31:0] makeWord(input logic [4:0] op, input logic [3:0] dest,
			input logic [3:0] src, input logic useImm, input logic sx, input logic [7:0] imm8);
		return {imm8, 6'b0, sx, useImm, src, dest, 3'b0, op};
	endfunction

	function automatic void refAlu(input logic [4:0] op, input logic [15:0] a,
			input logic [15:0] b, input aluFlags flagsIn, output logic [15:0] res,
			output aluFlags flagsOut, output logic wr);
		logic [16:0] full;
		full = '0;
		res = b;
		flagsOut = flagsIn;
		wr = 1'b1;
		case (op)
			opAdd: begin
				full = {1'b0, a} + {1'b0, b};
				res = full[15:0];
				flagsOut[flagC] = full[16];
				flagsOut[flagF] = (a[15] == b[15]) && (res[15] != a[15]);
			end
			opSub: begin
				full = {1'b0, a} + {1'b0, ~b} + 17'd1;
				res = full[15:0];
				flagsOut[flagC] = full[16];
				flagsOut[flagF] = (a[15] != b[15]) && (res[15] != a[15]);
			end
			opCmp: wr = 1'b0;
			opAnd: res = a & b;
			opOr: res = a | b;
			opXor: res = a ^ b;
			opNot: res = ~b;
			opLsh: res = {b[14:0], 1'b0};
			opRsh: res = {1'b0, b[15:1]};
			opArsh: res = {b[15], b[15:1]};
			default: res = b;
		endcase
		// ADD, SUB and CMP all compare the destination against b
		if (op <= opCmp) begin
			flagsOut[flagL] = a < b;
			flagsOut[flagZ] = a == b;
			flagsOut[flagN] = $signed(a) < $signed(b);
		end
	endfunction

	function automatic void applyModel(input logic [31:0] word);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		aluFlags newFlags;
		logic wr;
		a = modelRegs[word[11:8]];
		b = word[16] ? immExtend(word[31:24], word[17]) : modelRegs[word[15:12]];
		refAlu(word[4:0], a, b, modelFlags, res, newFlags, wr);
		if (wr) begin
			modelRegs[word[11:8]] = res;
		end
		modelFlags = newFlags;
	endfunction

	function automatic logic [busWidth-1:0] modelData(input logic [addrWidth-1:0] addr);
		if (addr < flagAddr && addr[1:0] == 2'b00) begin
			return {16'h0000, modelRegs[addr[5:2]]};
		end
		return (addr == flagAddr) ? {27'h0, modelFlags} : '0;
	endfunction

	function automatic logic [1:0] modelResp(input logic [addrWidth-1:0] addr);
		if ((addr < flagAddr && addr[1:0] == 2'b00) || addr == flagAddr) begin
			return respOkay;
		end
		return respSlvErr;
	endfunction

	function automatic logic [31:0] randomInstr();
		logic [4:0] op;
		op = 5'($urandom % 11);
		return makeWord(op, 4'($urandom), 4'($urandom), 1'($urandom), 1'($urandom),
			8'($urandom));
	endfunction

	// ------------------------------
	// Run control
	// ------------------------------
	task automatic printSummary();
		$display("Summary: %0d responses checked, %0d errors", checkCount, errorCount);
	endtask

	task automatic reportTimeout(input string reason);
		errorCount++;
		$display("ERROR: %s", reason);
	endtask

	// ------------------------------
	// AXI4-Lite host tasks
	// ------------------------------
	task automatic writeWord(input logic [addrWidth-1:0] addr, input logic [busWidth-1:0] data,
			input logic [1:0] expResp, input int bDelay);
		int waitCycles;
		waitCycles = 0;
		expBrespQ.push_back(expResp);
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (!(awready && wready) && waitCycles < timeoutCycles) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!(awready && wready)) begin
			reportTimeout("write address and data were never accepted");
		end
		// Taken at the rising edge in between
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		repeat (bDelay) @(negedge clk);
		bready = 1'b1;
		waitCycles = 0;
		while (!bvalid && waitCycles < timeoutCycles) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!bvalid) begin
			reportTimeout("write response never arrived");
		end
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic sendInstr(input logic [31:0] word, input int bDelay);
		applyModel(word);
		writeWord(instrAddr, word, respOkay, bDelay);
	endtask

	// Writes issued as fast as the port takes them with bready held high
	task automatic burstWrite(input int count);
		logic [31:0] word;
		int waitCycles;
		bready = 1'b1;
		@(negedge clk);
		for (int n = 0; n < count; n++) begin
			word = (n == count - 1) ? makeWord(opMov, 4'd7, 4'd0, 1'b1, 1'b0, 8'h5A)
				: randomInstr();
			applyModel(word);
			expBrespQ.push_back(respOkay);
			awaddr = instrAddr;
			wdata = word;
			awvalid = 1'b1;
			wvalid = 1'b1;
			waitCycles = 0;
			while (!(awready && wready) && waitCycles < timeoutCycles) begin
				@(negedge clk);
				waitCycles++;
			end
			if (!(awready && wready)) begin
				reportTimeout("burst write was never accepted");
			end
			@(negedge clk);
		end
		// The last instruction is still queued and its response still pending here
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic readExpect(input logic [addrWidth-1:0] addr,
			input logic [busWidth-1:0] expData, input logic [1:0] expResp);
		int waitCycles;
		waitCycles = 0;
		expAddrQ.push_back(addr);
		expRdataQ.push_back(expData);
		expRrespQ.push_back(expResp);
		araddr = addr;
		arvalid = 1'b1;
		while (!arready && waitCycles < timeoutCycles) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!arready) begin
			reportTimeout("read address was never accepted");
		end
		@(negedge clk);
		arvalid = 1'b0;
		waitCycles = 0;
		while (!rvalid && waitCycles < timeoutCycles) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!rvalid) begin
			reportTimeout("read data never arrived");
		end
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic readModel(input logic [addrWidth-1:0] addr);
		readExpect(addr, modelData(addr), modelResp(addr));
	endtask

	task automatic readAll();
		for (int i = 0; i < regCount; i++) begin
			readModel(regBase + addrWidth'(4 * i));
		end
		readModel(flagAddr);
	endtask

	// ------------------------------
	// Response checker
	// ------------------------------
	always @(posedge clk) begin : checkResponses
		logic [1:0] expB;
		logic [addrWidth-1:0] expAddr;
		logic [busWidth-1:0] expData;
		logic [1:0] expResp;
		if (rstN && bvalid && bready) begin
			if (expBrespQ.size() == 0) begin
				errorCount++;
				$display("ERROR: write response arrived with no write outstanding");
			end else begin
				expB = expBrespQ.pop_front();
				checkCount++;
				if (bresp !== expB) begin
					errorCount++;
					$display("MISMATCH bresp: expected 0x%h actual 0x%h", expB, bresp);
				end
			end
		end
		if (rstN && rvalid && rready) begin
			if (expRdataQ.size() == 0) begin
				errorCount++;
				$display("ERROR: read response arrived with no read outstanding");
			end else begin
				expAddr = expAddrQ.pop_front();
				expData = expRdataQ.pop_front();
				expResp = expRrespQ.pop_front();
				checkCount++;
				if (rdata !== expData) begin
					errorCount++;
					$display("MISMATCH rdata at 0x%h: expected 0x%h actual 0x%h",
						expAddr, expData, rdata);
				end
				if (rresp !== expResp) begin
					errorCount++;
					$display("MISMATCH rresp at 0x%h: expected 0x%h actual 0x%h",
						expAddr, expResp, rresp);
				end
			end
		end
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin : mainSequence
		void'($urandom(65));
		clk = 1'b0;
		rstN = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			modelRegs[i] = '0;
		end
		modelFlags = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Everything is zero out of reset
		readAll();

		// Load every register from a random immediate
		for (int r = 0; r < regCount; r++) begin
			sendInstr(makeWord(opMov, 4'(r), 4'h0, 1'b1, 1'(r % 2), 8'($urandom)), 0);
		end
		readAll();

		for (int n = 1; n <= 200; n++) begin
			sendInstr(randomInstr(), 0);
			if (n % 20 == 0) begin
				readAll();
			end
		end

		// Adder corners with flags read as {N, Z, F, L, C}
		sendInstr(makeWord(opMov, 4'd1, 4'd0, 1'b1, 1'b1, 8'hFF), 0);
		sendInstr(makeWord(opRsh, 4'd1, 4'd1, 1'b0, 1'b0, 8'h00), 0);
		sendInstr(makeWord(opAdd, 4'd1, 4'd0, 1'b1, 1'b0, 8'h01), 0);
		readExpect(32'h04, 32'h8000, respOkay);
		readExpect(flagAddr, 32'h04, respOkay);
		sendInstr(makeWord(opMov, 4'd2, 4'd0, 1'b1, 1'b1, 8'hFF), 0);
		sendInstr(makeWord(opAdd, 4'd2, 4'd0, 1'b1, 1'b0, 8'h01), 0);
		readExpect(32'h08, 32'h0000, respOkay);
		readExpect(flagAddr, 32'h11, respOkay);
		sendInstr(makeWord(opMov, 4'd3, 4'd1, 1'b0, 1'b0, 8'h00), 0);
		sendInstr(makeWord(opSub, 4'd3, 4'd0, 1'b1, 1'b0, 8'h01), 0);
		readExpect(32'h0C, 32'h7FFF, respOkay);
		readExpect(flagAddr, 32'h15, respOkay);
		sendInstr(makeWord(opMov, 4'd4, 4'd0, 1'b1, 1'b0, 8'h55), 0);
		sendInstr(makeWord(opSub, 4'd4, 4'd0, 1'b1, 1'b0, 8'h55), 0);
		readExpect(32'h10, 32'h0000, respOkay);
		readExpect(flagAddr, 32'h09, respOkay);
		sendInstr(makeWord(opMov, 4'd5, 4'd0, 1'b1, 1'b0, 8'h03), 0);
		sendInstr(makeWord(opCmp, 4'd5, 4'd0, 1'b1, 1'b0, 8'h07), 0);
		readExpect(32'h14, 32'h0003, respOkay);
		readExpect(flagAddr, 32'h13, respOkay);

		// Rejected accesses leave the state alone
		writeWord(instrAddr, makeWord(5'd20, 4'd6, 4'd0, 1'b1, 1'b0, 8'h12), respSlvErr, 0);
		writeWord(32'h10, makeWord(opMov, 4'd6, 4'd0, 1'b1, 1'b0, 8'hAA), respSlvErr, 0);
		readExpect(32'h44, 32'h0, respSlvErr);
		readExpect(32'h100, 32'h0, respSlvErr);
		readAll();

		// Slow response acceptance, then a burst and a read straight after it
		for (int n = 0; n < 6; n++) begin
			sendInstr(randomInstr(), 1 + n % 3);
		end
		burstWrite(8);
		readModel(32'h1C);
		bready = 1'b0;
		readAll();

		if (expBrespQ.size() != 0 || expRdataQ.size() != 0) begin
			errorCount++;
			$display("ERROR: some expected responses never arrived");
		end
		printSummary();
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
hdl/aluPkg.sv
hdl/aluCore.sv
hdl/instrFifo.sv
hdl/executeUnit.sv
hdl/aluBusPort.sv
hdl/aluTop.sv
tb/aluTop_assert.sv
tb/aluTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module aluTb -f sim.f -o aluSim

./obj_dir/aluSim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation finished without failure"
exit 0
